// ==== sources.f ====
+incdir+include
rtl/laser_pkg.sv
rtl/point_store.sv
rtl/coverage_counter.sv
rtl/best_center_tracker.sv
rtl/laser_ctrl.sv
rtl/laser_top.sv
verif/laser_tb.sv

// ==== Bender.yml ====
package:
  name: laser_search

sources:
  - files:
      - rtl/laser_pkg.sv
      - rtl/point_store.sv
      - rtl/coverage_counter.sv
      - rtl/best_center_tracker.sv
      - rtl/laser_ctrl.sv
      - rtl/laser_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/laser_tb.sv

// ==== include/laser_ref.svh ====
// Reference model of the greedy two-centre search, for the testbench.
// Include inside a scope that already imports laser_pkg.
`ifndef LASER_REF_SVH
`define LASER_REF_SVH

// Point inside the radius-4 circle around (cx,cy)
function automatic bit covers(coord_t px, coord_t py, coord_t cx, coord_t cy);
    int dx;
    int dy;
    dx = int'(px) - int'(cx);
    dy = int'(py) - int'(cy);
    return (dx * dx + dy * dy) <= RADIUS_SQ;
endfunction

// Two raster passes; strict improvement only, so ties keep the earliest position
function automatic void best_pair(
    input  coord_t px [NUM_POINTS],
    input  coord_t py [NUM_POINTS],
    output coord_t c1x,
    output coord_t c1y,
    output coord_t c2x,
    output coord_t c2y
);
    int     best;
    int     count;
    coord_t cx;
    coord_t cy;
    for (int pass = 0; pass < 2; pass++)
    begin
        best = -1;
        for (int idx = 0; idx < NUM_CAND; idx++)
        begin
            cx    = coord_t'(idx % GRID_SIZE);
            cy    = coord_t'(idx / GRID_SIZE);
            count = 0;
            for (int i = 0; i < NUM_POINTS; i++)
            begin
                if (covers(px[i], py[i], cx, cy) &&
                    !(pass == 1 && covers(px[i], py[i], c1x, c1y)))
                begin
                    count++;
                end
            end
            if (count > best && pass == 0)
            begin
                best = count;
                c1x  = cx;
                c1y  = cy;
            end
            else if (count > best)
            begin
                best = count;
                c2x  = cx;
                c2y  = cy;
            end
        end
    end
endfunction

`endif

// ==== verif/laser_tb.sv ====
// Testbench for the two-centre laser search.
// Streams seven back-to-back jobs into laser_top and checks each result
// against the greedy reference model from laser_ref.svh.
`timescale 1ns/100ps
`default_nettype none

module laser_tb
    import laser_pkg::*;
;

    `include "laser_ref.svh"

    // ========================================================================
    // Run constants
    // ========================================================================

    localparam int SEED           = 9;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_JOBS       = 7;
    localparam int IDENT_JOB      = 2;
    // Cycles from the last load edge to the first load edge of the next job
    localparam int JOB_GAP        = 2 * NUM_CAND + 2 * DRAIN_LEN + 1;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * 600 + RESET_CYCLES;

    logic    CLK;
    logic    RST;
    coord_t  x;
    coord_t  y;
    coord_t  c1x;
    coord_t  c1y;
    coord_t  c2x;
    coord_t  c2y;
    logic    done;

    string   exp_name [$];
    coord_t  exp_c1x [$];
    coord_t  exp_c1y [$];
    coord_t  exp_c2x [$];
    coord_t  exp_c2y [$];
    int      cycle_count = 0;
    logic    prev_done   = 1'b0;

    laser_top uut (
        .CLK, .RST, .x, .y,
        .c1x, .c1y, .c2x, .c2y, .done
    );

    always #5 CLK = ~CLK;

    // ========================================================================
    // Failure reporting
    // ========================================================================

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input int expected, input int actual);
        stop_with_failure($sformatf("mismatch test=%s %s expected=%0d actual=%0d",
                                    test, field, expected, actual));
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    function automatic string job_name(input int j);
        case (j)
            1:         return "two_clusters";
            IDENT_JOB: return "identical_points";
            3:         return "corners_edges";
            default:   return $sformatf("random_%0d", j);
        endcase
    endfunction

    // Earliest raster candidate that covers a single point
    function automatic void first_cover(input coord_t px, input coord_t py,
                                        output coord_t cx, output coord_t cy);
        bit found;
        found = 1'b0;
        cx    = '0;
        cy    = '0;
        for (int idx = 0; idx < NUM_CAND; idx++)
        begin
            if (!found && covers(px, py, coord_t'(idx % GRID_SIZE), coord_t'(idx / GRID_SIZE)))
            begin
                found = 1'b1;
                cx    = coord_t'(idx % GRID_SIZE);
                cy    = coord_t'(idx / GRID_SIZE);
            end
        end
    endfunction

    task automatic make_points(input int j, output coord_t px [NUM_POINTS],
                               output coord_t py [NUM_POINTS]);
        coord_t  sx;
        coord_t  sy;
        coord_t  pos;
        int      e;
        sx = coord_t'($urandom_range(0, GRID_SIZE - 1));
        sy = coord_t'($urandom_range(0, GRID_SIZE - 1));
        for (int k = 0; k < NUM_POINTS; k++)
        begin
            e   = k - 4;
            pos = coord_t'((e * 7) % GRID_SIZE);
            if (j == 1)
            begin
                // Two groups of twenty, around (3,3) and (12,11)
                px[k] = coord_t'((k < 20 ? 3 : 12) + $urandom_range(0, 2) - 1);
                py[k] = coord_t'((k < 20 ? 3 : 11) + $urandom_range(0, 2) - 1);
            end
            else if (j == IDENT_JOB)
            begin
                px[k] = sx;
                py[k] = sy;
            end
            else if (j == 3 && k < 4)
            begin
                px[k] = (k & 1) ? coord_t'(GRID_SIZE - 1) : '0;
                py[k] = (k & 2) ? coord_t'(GRID_SIZE - 1) : '0;
            end
            else if (j == 3)
            begin
                px[k] = (e % 4 == 2) ? '0 : (e % 4 == 3) ? coord_t'(GRID_SIZE - 1) : pos;
                py[k] = (e % 4 == 0) ? '0 : (e % 4 == 1) ? coord_t'(GRID_SIZE - 1) : pos;
            end
            else
            begin
                px[k] = coord_t'($urandom_range(0, GRID_SIZE - 1));
                py[k] = coord_t'($urandom_range(0, GRID_SIZE - 1));
            end
        end
    endtask

    // ========================================================================
    // Reset and job stream
    // ========================================================================

    initial
    begin : stimulus
        coord_t px [NUM_POINTS];
        coord_t py [NUM_POINTS];
        coord_t e1x;
        coord_t e1y;
        coord_t e2x;
        coord_t e2y;
        void'($urandom(SEED));
        CLK = 1'b0;
        RST = 1'b1;
        x   = '0;
        y   = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RST <= 1'b0;
        for (int j = 0; j < NUM_JOBS; j++)
        begin
            make_points(j, px, py);
            best_pair(px, py, e1x, e1y, e2x, e2y);
            // All points equal, so pass two sees only zero counts
            if (j == IDENT_JOB)
            begin
                first_cover(px[0], py[0], e1x, e1y);
                e2x = '0;
                e2y = '0;
            end
            exp_name.push_back(job_name(j));
            exp_c1x.push_back(e1x);
            exp_c1y.push_back(e1y);
            exp_c2x.push_back(e2x);
            exp_c2y.push_back(e2y);
            for (int k = 0; k < NUM_POINTS; k++)
            begin
                x <= px[k];
                y <= py[k];
                @(posedge CLK);
            end
            repeat (JOB_GAP) @(posedge CLK);
        end
    end

    // ========================================================================
    // Response checking, sampled mid-cycle
    // ========================================================================

    initial
    begin : response_check
        int     jobs_seen;
        string  name;
        coord_t e1x;
        coord_t e1y;
        coord_t e2x;
        coord_t e2y;
        jobs_seen = 0;
        while (jobs_seen <= NUM_JOBS)
        begin
            @(negedge CLK);
            assert (!(prev_done && done))
            else stop_with_failure("done stayed high for more than one cycle");
            if (done && exp_name.size() == 0)
            begin
                stop_with_failure("done pulse without a loaded job");
            end
            else if (done)
            begin
                name = exp_name.pop_front();
                e1x  = exp_c1x.pop_front();
                e1y  = exp_c1y.pop_front();
                e2x  = exp_c2x.pop_front();
                e2y  = exp_c2y.pop_front();
                assert (c1x == e1x) else report_mismatch(name, "c1x", e1x, c1x);
                assert (c1y == e1y) else report_mismatch(name, "c1y", e1y, c1y);
                assert (c2x == e2x) else report_mismatch(name, "c2x", e2x, c2x);
                assert (c2y == e2y) else report_mismatch(name, "c2y", e2y, c2y);
                jobs_seen++;
            end
            else
            begin
                assert ({c1x, c1y, c2x, c2y} == '0)
                else report_mismatch("idle", "centres", 0, {c1x, c1y, c2x, c2y});
                // One quiet cycle after the final pulse closes the run
                if (jobs_seen == NUM_JOBS)
                begin
                    jobs_seen++;
                end
            end
            prev_done = done;
        end
        $display("Verification passed");
        $finish;
    end

    // Run limit
    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_with_failure("no done pulse before timeout");
        end
    end

endmodule

`default_nettype wire

// ==== rtl/laser_top.sv ====
// Top level of the two-centre laser search.
// Points stream in on x and y; both centres come out with a done pulse.
`timescale 1ns/100ps
`default_nettype none

module laser_top
    import laser_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  coord_t  x,
    input  coord_t  y,
    output coord_t  c1x,
    output coord_t  c1y,
    output coord_t  c2x,
    output coord_t  c2y,
    output logic    done
);

    logic        wr_en;
    logic [5:0]  wr_idx;
    coord_t      pts_x [NUM_POINTS];
    coord_t      pts_y [NUM_POINTS];
    coord_t      cand_x;
    coord_t      cand_y;
    logic        cand_valid;
    logic        cand_last;
    logic        second_pass;
    count_t      cnt;
    coord_t      cnt_x;
    coord_t      cnt_y;
    logic        cnt_valid;
    logic        cnt_last;
    coord_t      c1_x;
    coord_t      c1_y;
    coord_t      c2_x;
    coord_t      c2_y;

    point_store u_store (
        .CLK, .RST, .wr_en, .wr_idx,
        .wr_x (x),
        .wr_y (y),
        .pts_x, .pts_y
    );

    coverage_counter u_counter (
        .CLK, .RST, .pts_x, .pts_y,
        .cand_x, .cand_y, .cand_valid, .cand_last, .second_pass,
        .c1_x, .c1_y,
        .cnt, .cnt_x, .cnt_y, .cnt_valid, .cnt_last
    );

    best_center_tracker u_tracker (
        .CLK, .RST, .cnt, .cnt_x, .cnt_y, .cnt_valid, .cnt_last, .second_pass,
        .c1_x, .c1_y, .c2_x, .c2_y
    );

    laser_ctrl u_ctrl (
        .CLK, .RST, .c1_x, .c1_y, .c2_x, .c2_y,
        .wr_en, .wr_idx, .cand_x, .cand_y, .cand_valid, .cand_last, .second_pass,
        .c1x, .c1y, .c2x, .c2y, .done
    );

endmodule

`default_nettype wire

// ==== rtl/laser_ctrl.sv ====
// Sequencer for one job: 40-cycle load, two raster passes with drains, output.
// A single step counter is the load index and the candidate index.
`timescale 1ns/100ps
`default_nettype none

module laser_ctrl
    import laser_pkg::*;
(
    input  logic        CLK,
    input  logic        RST,
    input  coord_t      c1_x,
    input  coord_t      c1_y,
    input  coord_t      c2_x,
    input  coord_t      c2_y,
    output logic        wr_en,
    output logic [5:0]  wr_idx,
    output coord_t      cand_x,
    output coord_t      cand_y,
    output logic        cand_valid,
    output logic        cand_last,
    output logic        second_pass,
    output coord_t      c1x,
    output coord_t      c1y,
    output coord_t      c2x,
    output coord_t      c2y,
    output logic        done
);

    laser_state_e       state;
    laser_state_e       state_nxt;
    logic [CAND_W-1:0]  step;
    logic               step_end;

    // ========================================================================
    // State machine and step counter
    // ========================================================================

    always_comb
    begin
        case (state)
            ST_LOAD:             step_end = (step == CAND_W'(NUM_POINTS - 1));
            ST_PASS1, ST_PASS2:  step_end = (step == CAND_W'(NUM_CAND - 1));
            ST_DRAIN1, ST_DRAIN2: step_end = (step == CAND_W'(DRAIN_LEN - 1));
            default:             step_end = 1'b1;
        endcase
    end

    always_comb
    begin
        state_nxt = state;
        if (step_end)
        begin
            case (state)
                ST_LOAD:   state_nxt = ST_PASS1;
                ST_PASS1:  state_nxt = ST_DRAIN1;
                ST_DRAIN1: state_nxt = ST_PASS2;
                ST_PASS2:  state_nxt = ST_DRAIN2;
                ST_DRAIN2: state_nxt = ST_DONE;
                default:   state_nxt = ST_LOAD;
            endcase
        end
    end

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state <= ST_LOAD;
            step  <= '0;
        end
        else
        begin
            state <= state_nxt;
            step  <= step_end ? '0 : step + 1'b1;
        end
    end

    // ========================================================================
    // Load and candidate issue
    // ========================================================================

    assign wr_en       = (state == ST_LOAD);
    assign wr_idx      = step[5:0];
    assign cand_x      = step[COORD_W-1:0];
    assign cand_y      = step[CAND_W-1:COORD_W];
    assign cand_valid  = (state == ST_PASS1) || (state == ST_PASS2);
    assign cand_last   = cand_valid && (step == CAND_W'(NUM_CAND - 1));
    // Held through the drain so the tracker files the winner under C2
    assign second_pass = (state == ST_PASS2) || (state == ST_DRAIN2);

    // ========================================================================
    // Output stage
    // ========================================================================

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            done <= 1'b0;
            c1x  <= '0;
            c1y  <= '0;
            c2x  <= '0;
            c2y  <= '0;
        end
        else
        begin
            done <= (state == ST_DONE);
            c1x  <= (state == ST_DONE) ? c1_x : '0;
            c1y  <= (state == ST_DONE) ? c1_y : '0;
            c2x  <= (state == ST_DONE) ? c2_x : '0;
            c2y  <= (state == ST_DONE) ? c2_y : '0;
        end
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
        done |=> !done);

endmodule

`default_nettype wire

// ==== rtl/best_center_tracker.sv ====
// Tracks the best candidate of the running pass and keeps both centres.
// The first candidate opens a pass; only a strictly larger count replaces it.
`timescale 1ns/100ps
`default_nettype none

module best_center_tracker
    import laser_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  count_t  cnt,
    input  coord_t  cnt_x,
    input  coord_t  cnt_y,
    input  logic    cnt_valid,
    input  logic    cnt_last,
    input  logic    second_pass,
    output coord_t  c1_x,
    output coord_t  c1_y,
    output coord_t  c2_x,
    output coord_t  c2_y
);

    logic    in_pass;
    logic    take;
    count_t  best_cnt;
    coord_t  best_x;
    coord_t  best_y;
    coord_t  win_x;
    coord_t  win_y;

    // Ties keep the earlier raster position
    assign take  = !in_pass || (cnt > best_cnt);
    assign win_x = take ? cnt_x : best_x;
    assign win_y = take ? cnt_y : best_y;

    always_ff @(posedge CLK)
    begin
        if (cnt_valid && take)
        begin
            best_cnt <= cnt;
            best_x   <= cnt_x;
            best_y   <= cnt_y;
        end
    end

    // Pass winner goes to C1 or C2 on the last candidate
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            in_pass <= 1'b0;
            c1_x    <= '0;
            c1_y    <= '0;
            c2_x    <= '0;
            c2_y    <= '0;
        end
        else if (cnt_valid)
        begin
            in_pass <= !cnt_last;
            if (cnt_last && !second_pass)
            begin
                c1_x <= win_x;
                c1_y <= win_y;
            end
            else if (cnt_last)
            begin
                c2_x <= win_x;
                c2_y <= win_y;
            end
        end
    end

    a_best_monotonic: assert property (@(posedge CLK) disable iff (RST)
        (cnt_valid && in_pass) |=> (best_cnt >= $past(best_cnt)));

endmodule

`default_nettype wire

// ==== rtl/coverage_counter.sv ====
// Counts the points that fall inside the circle around one candidate.
// In pass two the points already inside C1 are left out. One cycle latency.
`timescale 1ns/100ps
`default_nettype none

module coverage_counter
    import laser_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  coord_t  pts_x [NUM_POINTS],
    input  coord_t  pts_y [NUM_POINTS],
    input  coord_t  cand_x,
    input  coord_t  cand_y,
    input  logic    cand_valid,
    input  logic    cand_last,
    input  logic    second_pass,
    input  coord_t  c1_x,
    input  coord_t  c1_y,
    output count_t  cnt,
    output coord_t  cnt_x,
    output coord_t  cnt_y,
    output logic    cnt_valid,
    output logic    cnt_last
);

    logic [NUM_POINTS-1:0] hit;
    count_t                hit_sum;

    // Absolute differences never wrap, so edge points are measured correctly
    function automatic logic within_radius(coord_t ax, coord_t ay, coord_t bx, coord_t by);
        coord_t              dx;
        coord_t              dy;
        logic [2*COORD_W:0]  dist_sq;
        dx      = (ax > bx) ? ax - bx : bx - ax;
        dy      = (ay > by) ? ay - by : by - ay;
        dist_sq = dx * dx + dy * dy;
        return dist_sq <= RADIUS_SQ;
    endfunction

    // ========================================================================
    // Per-point distance test
    // ========================================================================

    always_comb
    begin
        for (int i = 0; i < NUM_POINTS; i++)
        begin
            hit[i] = within_radius(pts_x[i], pts_y[i], cand_x, cand_y) &&
                     !(second_pass && within_radius(pts_x[i], pts_y[i], c1_x, c1_y));
        end
    end

    // Population count of the hits
    always_comb
    begin
        hit_sum = '0;
        for (int i = 0; i < NUM_POINTS; i++)
        begin
            hit_sum = hit_sum + count_t'(hit[i]);
        end
    end

    // ========================================================================
    // Result register
    // ========================================================================

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            cnt_valid <= 1'b0;
            cnt_last  <= 1'b0;
        end
        else
        begin
            cnt_valid <= cand_valid;
            cnt_last  <= cand_valid && cand_last;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cand_valid)
        begin
            cnt   <= hit_sum;
            cnt_x <= cand_x;
            cnt_y <= cand_y;
        end
    end

    a_cnt_bound: assert property (@(posedge CLK) disable iff (RST)
        cnt_valid |-> (cnt <= NUM_POINTS));

endmodule

`default_nettype wire

// ==== rtl/point_store.sv ====
// Register file for the forty points of one job.
// Written one entry per cycle during the load window, read all at once.
`timescale 1ns/100ps
`default_nettype none

module point_store
    import laser_pkg::*;
(
    input  logic        CLK,
    input  logic        RST,
    input  logic        wr_en,
    input  logic [5:0]  wr_idx,
    input  coord_t      wr_x,
    input  coord_t      wr_y,
    output coord_t      pts_x [NUM_POINTS],
    output coord_t      pts_y [NUM_POINTS]
);

    coord_t mem_x [NUM_POINTS];
    coord_t mem_y [NUM_POINTS];

    // Capture on the same edge the controller samples the inputs
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            for (int i = 0; i < NUM_POINTS; i++)
            begin
                mem_x[i] <= '0;
                mem_y[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            mem_x[wr_idx] <= wr_x;
            mem_y[wr_idx] <= wr_y;
        end
    end

    // Whole array visible to the distance logic
    always_comb
    begin
        for (int i = 0; i < NUM_POINTS; i++)
        begin
            pts_x[i] = mem_x[i];
            pts_y[i] = mem_y[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/laser_pkg.sv ====
// Shared constants, types and controller states for the laser centre search.
// Every RTL block and the testbench pull this in with a wildcard import.
`default_nettype none

package laser_pkg;

    // ========================================================================
    // Grid and job geometry
    // ========================================================================

    // Coordinate width, one axis of the grid
    localparam int COORD_W = 4;

    // Grid positions per axis
    localparam int GRID_SIZE = 16;

    // Points delivered per job
    localparam int NUM_POINTS = 40;

    // Every grid position is a candidate centre
    localparam int NUM_CAND = GRID_SIZE * GRID_SIZE;

    // Raster index of a candidate, y in the upper nibble
    localparam int CAND_W = 8;

    // Circle of radius 4
    localparam int RADIUS_SQ = 16;

    // Wide enough to hold NUM_POINTS
    localparam int CNT_W = 6;

    // Cycles between a pass and the next stage
    localparam int DRAIN_LEN = 2;

    // ========================================================================
    // Types
    // ========================================================================

    typedef logic [COORD_W-1:0] coord_t;

    typedef logic [CNT_W-1:0] count_t;

    // Controller sequence, load through output
    typedef enum logic [2:0] {
        ST_LOAD,
        ST_PASS1,
        ST_DRAIN1,
        ST_PASS2,
        ST_DRAIN2,
        ST_DONE
    } laser_state_e;

endpackage

`default_nettype wire
